/* vlog.f */
+incdir+.
spi_pkg.sv
spi_edge_sync.sv
spi_slave.sv
spi_reg_ctrl.sv
spi_reg_top.sv
tb_clk_gen.sv
tb_spi_reg_top.sv

/* Bender.yml */
package:
  name: spi_reg_slave

export_include_dirs:
  - .

sources:
  # rtl in compile order
  - spi_pkg.sv
  - spi_edge_sync.sv
  - spi_slave.sv
  - spi_reg_ctrl.sv
  - spi_reg_top.sv

  # testbench
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_spi_reg_top.sv

/* tb_spi_reg_top.sv */
//----------------------------------------------------------------------
// spi register slave testbench
// lfsr-driven spi master, register bank model and frame checks
//----------------------------------------------------------------------
`include "spi_macros.svh"
`default_nettype none

module tb_spi_reg_top;
	import spi_pkg::*;

	localparam int HALF    = 8;             // sys_clk cycles per sclk half period
	localparam int GAP     = 16;            // idle cycles after cs rises
	localparam int TIMEOUT = 200;           // bound for every pulse wait

	logic        sys_clk;
	logic        sys_rst_n;
	spi_pins_t   pins;
	logic        miso;
	spi_reg_wr_t reg_wr;
	logic        op_err;

	logic [31:0] lfsr;                      // random state
	logic [7:0]  model [`SPI_REG_DEPTH];    // expected register bank
	int          wr_cnt = 0;                // reg_wr.en pulses seen
	int          err_cnt = 0;               // op_err pulses seen
	spi_reg_wr_t wr_last;                   // last reported write

	tb_clk_gen tb_clk_gen_i (.clk(sys_clk));

	spi_reg_top spi_reg_top_i (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.pins      (pins),
		.miso      (miso),
		.reg_wr    (reg_wr),
		.op_err    (op_err)
	);

	// pulse monitor, mid-cycle where outputs are settled
	always @(negedge sys_clk) begin
		if (reg_wr.en) begin
			wr_cnt++;
			wr_last = reg_wr;
		end
		if (op_err) begin
			err_cnt++;
		end
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one lfsr step per bit taken
	task automatic take_bits(input int n, output logic [7:0] val);
		val = 8'h00;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			val  = {val[6:0], lfsr[0]};
		end
	endtask

	task automatic take_bad_op(output logic [7:0] op);
		take_bits(8, op);
		if ((op == OP_WRITE) || (op == OP_READ)) begin
			op = op ^ 8'h80;                // force an unknown opcode
		end
	endtask

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_val(input string name, input string what,
	                         input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp) else begin
			fail_now($sformatf("** Error: %s %s expected %0h actual %0h",
			                   name, what, exp, act));
		end
	endtask

	// inputs move 1 unit after the rising edge
	task automatic step(input int n);
		repeat (n) begin
			@(posedge sys_clk);
			#1;
		end
	endtask

	// bounded wait for a write or op_err counter to move
	task automatic wait_pulse(input bit on_err, input int old, input string name);
		int t;
		t = 0;
		while (((on_err ? err_cnt : wr_cnt) == old) && (t < TIMEOUT)) begin
			step(1);
			t++;
		end
		if ((on_err ? err_cnt : wr_cnt) == old) begin
			fail_now($sformatf("%s: no %s pulse within %0d cycles", name,
			                   on_err ? "op_err" : "reg_wr.en", TIMEOUT));
		end
	endtask

	// one byte msb first, fewer than 8 bits leaves it unfinished
	task automatic xfer_byte(input logic [7:0] tx, input int nbits, output logic [7:0] rx);
		rx = 8'h00;
		for (int i = 0; i < nbits; i++) begin
			if (`SPI_CPHA) begin
				pins.sclk = ~`SPI_CPOL;         // leading edge, slave shifts
			end
			pins.mosi = tx[7-i];
			step(HALF);
			rx        = {rx[6:0], miso};    // master samples here
			pins.sclk = ~pins.sclk;         // sample edge
			step(HALF);
			if (!`SPI_CPHA) begin
				pins.sclk = `SPI_CPOL;          // trailing edge
			end
		end
	endtask

	task automatic run_frame(input logic [7:0] op, addr, data, input int data_bits,
	                         output logic [7:0] r0, r1, r2);
		pins.cs = 1'b0;                     // frame start
		step(HALF);
		xfer_byte(op, 8, r0);
		xfer_byte(addr, 8, r1);
		xfer_byte(data, data_bits, r2);
		if (!`SPI_CPHA) begin
			step(HALF);                     // hold after last trailing edge
		end
		pins.cs   = 1'b1;
		pins.mosi = 1'b0;
		step(GAP);                          // frame_end reaches the controller
	endtask

	// full frame with miso, write and op_err checks; model follows writes
	task automatic do_frame(input string name, input logic [7:0] op, addr, data,
	                        input int data_bits);
		logic [7:0] r0, r1, r2;
		logic [7:0] exp_rd;
		int         wr_old;
		int         err_old;
		int         is_wr;
		int         bad_op;
		wr_old  = wr_cnt;
		err_old = err_cnt;
		is_wr   = (op == OP_WRITE) && (data_bits == 8);
		bad_op  = (op != OP_WRITE) && (op != OP_READ);
		exp_rd  = (op == OP_READ) ? model[addr[`SPI_ADDR_W-1:0]] : 8'h00;
		run_frame(op, addr, data, data_bits, r0, r1, r2);
		check_val(name, "opcode byte miso", 8'h00, r0);
		check_val(name, "address byte miso", 8'h00, r1);
		if (data_bits == 8) begin
			check_val(name, "data byte miso", exp_rd, r2);
		end
		if (is_wr) begin
			wait_pulse(1'b0, wr_old, name);
			check_val(name, "write addr", addr[`SPI_ADDR_W-1:0], wr_last.addr);
			check_val(name, "write data", data, wr_last.data);
			model[addr[`SPI_ADDR_W-1:0]] = data;
		end
		if (bad_op) begin
			wait_pulse(1'b1, err_old, name);
		end
		check_val(name, "reg_wr pulses", wr_old + is_wr, wr_cnt);
		check_val(name, "op_err pulses", err_old + bad_op, err_cnt);
	endtask

	initial begin : main
		logic [7:0] kind;
		logic [7:0] op;
		logic [7:0] addr;
		logic [7:0] data;
		lfsr      = 32'h7137_ad83;
		sys_rst_n = 1'b0;
		pins      = '{cs: 1'b1, sclk: `SPI_CPOL, mosi: 1'b0};
		for (int i = 0; i < `SPI_REG_DEPTH; i++) begin
			model[i] = 8'h00;
		end
		step(10);
		sys_rst_n = 1'b1;

		// idle bus after reset
		for (int i = 0; i < 20; i++) begin
			step(1);
			check_val("reset", "miso", 0, miso);
			check_val("reset", "reg_wr.en", 0, reg_wr.en);
			check_val("reset", "op_err", 0, op_err);
		end

		for (int i = 0; i < 16; i++) begin
			take_bits(8, addr);
			take_bits(8, data);
			do_frame("write", OP_WRITE, addr, data, 8);
		end

		for (int i = 0; i < 16; i++) begin
			take_bits(8, addr);
			take_bits(8, data);             // dummy byte
			do_frame("read", OP_READ, addr, data, 8);
		end

		// bank must be untouched after a bad opcode
		for (int i = 0; i < 4; i++) begin
			take_bad_op(op);
			take_bits(8, addr);
			take_bits(8, data);
			do_frame("bad_opcode", op, addr, data, 8);
			do_frame("bad_opcode_readback", OP_READ, addr, 8'h00, 8);
		end

		// cs up after 4 data bits
		for (int i = 0; i < 4; i++) begin
			take_bits(8, addr);
			take_bits(8, data);
			do_frame("abort", OP_WRITE, addr, data, 4);
			do_frame("abort_readback", OP_READ, addr, 8'h00, 8);
		end

		for (int i = 0; i < 200; i++) begin
			take_bits(3, kind);
			take_bits(8, addr);
			take_bits(8, data);
			case (kind[2:0])
				3'd4, 3'd5: do_frame("soak_read", OP_READ, addr, data, 8);
				3'd6: begin
					take_bad_op(op);
					do_frame("soak_bad_opcode", op, addr, data, 8);
				end
				3'd7: do_frame("soak_abort", OP_WRITE, addr, data, 4);
				default: do_frame("soak_write", OP_WRITE, addr, data, 8);
			endcase
		end

		for (int i = 0; i < `SPI_REG_DEPTH; i++) begin
			do_frame("readback", OP_READ, 8'(i), 8'h00, 8);
		end

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* tb_clk_gen.sv */
//----------------------------------------------------------------------
// testbench clock source
// free-running sys_clk with a period of 4
//----------------------------------------------------------------------
`default_nettype none

module tb_clk_gen (
	output logic clk
);
	localparam int HALF_PERIOD = 2;         // period 4

	initial begin
		clk = 1'b0;
		forever begin
			#HALF_PERIOD clk = ~clk;
		end
	end

endmodule

`default_nettype wire

/* spi_reg_top.sv */
//----------------------------------------------------------------------
// spi register slave top
// pin synchronizer, byte engine and register controller
//----------------------------------------------------------------------
`default_nettype none

module spi_reg_top (
	input  logic                 sys_clk,
	input  logic                 sys_rst_n,
	input  spi_pkg::spi_pins_t   pins,
	output logic                 miso,
	output spi_pkg::spi_reg_wr_t reg_wr,
	output logic                 op_err
);
	import spi_pkg::*;

	spi_edges_t edges;                      // strobes in sys_clk domain
	spi_byte_t  rx_byte;                    // received byte + flags
	logic [7:0] tx_data;                    // next byte to send
	logic       frame_active;               // cs low as seen by engine

	spi_edge_sync spi_edge_sync_i (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.pins         (pins),
		.edges        (edges)
	);

	spi_slave spi_slave_i (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.edges        (edges),
		.tx_data      (tx_data),
		.miso         (miso),
		.rx_byte      (rx_byte),
		.frame_active (frame_active)
	);

	spi_reg_ctrl spi_reg_ctrl_i (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.rx_byte      (rx_byte),
		.frame_active (frame_active),
		.tx_data      (tx_data),
		.reg_wr       (reg_wr),
		.op_err       (op_err)
	);

endmodule

`default_nettype wire

/* spi_reg_ctrl.sv */
//----------------------------------------------------------------------
// spi register controller
// decodes opcode/addr/data frames into a 16 x 8 register bank
//----------------------------------------------------------------------
`include "spi_macros.svh"
`default_nettype none

module spi_reg_ctrl (
	input  logic                 sys_clk,
	input  logic                 sys_rst_n,
	input  spi_pkg::spi_byte_t   rx_byte,
	input  logic                 frame_active,
	output logic [7:0]           tx_data,
	output spi_pkg::spi_reg_wr_t reg_wr,
	output logic                 op_err
);
	import spi_pkg::*;

	spi_ctrl_state_e        state;
	spi_opcode_e            op_q;                      // opcode of current frame
	logic [`SPI_ADDR_W-1:0] addr_q;                    // latched register index
	logic [7:0]             regs [`SPI_REG_DEPTH];     // register bank
	logic                   op_valid;
	logic                   addr_hit;                  // address byte arrived
	logic                   wr_hit;                    // write data byte arrived

	assign op_valid = (rx_byte.data == OP_WRITE) || (rx_byte.data == OP_READ);
	assign addr_hit = rx_byte.valid && !rx_byte.first && (state == C_ADDR);
	assign wr_hit   = rx_byte.valid && !rx_byte.first && (state == C_DATA) &&
	                  (op_q == OP_WRITE);

	// frame fsm
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			state   <= C_OPCODE;
			op_q    <= OP_WRITE;
			op_err  <= 1'b0;
			tx_data <= 8'h00;
		end else if (!frame_active) begin
			state   <= C_OPCODE;                // cs high, wait for next frame
			op_err  <= 1'b0;
			tx_data <= 8'h00;
		end else begin
			op_err <= 1'b0;
			if (rx_byte.valid) begin
				if (rx_byte.first) begin
					if (op_valid) begin
						op_q  <= spi_opcode_e'(rx_byte.data);
						state <= C_ADDR;
					end else begin
						op_err <= 1'b1;         // unknown opcode
						state  <= C_IGNORE;     // rest of frame is don't care
					end
				end else begin
					case (state)
						C_ADDR: begin
							state <= C_DATA;
							if (op_q == OP_READ) begin
								// ready before the slave reloads its tx register
								tx_data <= regs[rx_byte.data[`SPI_ADDR_W-1:0]];
							end
						end
						C_DATA: begin
							state   <= C_IGNORE;    // no bursts
							tx_data <= 8'h00;       // dummy byte discarded on read
						end
						default: state <= C_IGNORE;
					endcase
				end
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (addr_hit) begin
			addr_q <= rx_byte.data[`SPI_ADDR_W-1:0];    // upper bits ignored
		end
	end

	// register bank
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			for (int i = 0; i < `SPI_REG_DEPTH; i++) begin
				regs[i] <= 8'h00;
			end
		end else if (wr_hit) begin
			regs[addr_q] <= rx_byte.data;
		end
	end

	// write report, one cycle after the data byte
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			reg_wr <= '0;
		end else begin
			reg_wr.en <= wr_hit;
			if (wr_hit) begin
				reg_wr.addr <= addr_q;
				reg_wr.data <= rx_byte.data;
			end
		end
	end

endmodule

`default_nettype wire

/* spi_slave.sv */
//----------------------------------------------------------------------
// spi slave byte engine
// shifts mosi in and miso out msb first, flags each finished byte
//----------------------------------------------------------------------
`include "spi_macros.svh"
`default_nettype none

module spi_slave (
	input  logic                sys_clk,
	input  logic                sys_rst_n,
	input  spi_pkg::spi_edges_t edges,
	input  logic [7:0]          tx_data,
	output logic                miso,
	output spi_pkg::spi_byte_t  rx_byte,
	output logic                frame_active
);
	import spi_pkg::*;

	spi_slave_state_e state;
	logic [3:0]       bit_cnt;              // samples taken in this byte
	logic [7:0]       rx_sr;                // mosi shift register
	logic [7:0]       tx_sr;                // bits still to present
	logic             first_q;              // opening byte of frame
	logic             rx_valid_q;           // byte done strobe
	logic             shift_en;             // shift edge that moves miso
	logic             rx_shift;
	logic             tx_shift;
	logic             tx_load;

	// with cpha=0 bit 7 is already out after a load, so the
	// trailing edge that closes the previous byte is skipped
	assign shift_en = edges.shift & (`SPI_CPHA | (bit_cnt != 4'd0));

	assign rx_shift = (state == S_WAIT_EDGE) && edges.sample;
	assign tx_shift = (state == S_WAIT_EDGE) && !edges.sample && shift_en;
	assign tx_load  = ((state == S_IDLE) && edges.frame_start) ||
	                  ((state == S_DONE) && !rx_valid_q);   // 2nd cycle of S_DONE

	assign rx_byte      = {rx_valid_q, first_q, rx_sr};
	assign frame_active = (state != S_IDLE);

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			state      <= S_IDLE;
			bit_cnt    <= 4'd0;
			first_q    <= 1'b0;
			rx_valid_q <= 1'b0;
			miso       <= 1'b0;
		end else if (edges.frame_end) begin
			state      <= S_IDLE;               // partial byte is dropped
			bit_cnt    <= 4'd0;
			first_q    <= 1'b0;
			rx_valid_q <= 1'b0;
			miso       <= 1'b0;
		end else begin
			rx_valid_q <= 1'b0;                 // pulse by default
			case (state)
				S_IDLE: begin
					if (edges.frame_start) begin
						state   <= S_WAIT_EDGE;
						bit_cnt <= 4'd0;
						first_q <= 1'b1;
						if (`SPI_CPHA == 1'b0) begin
							miso <= tx_data[7]; // first bit before first edge
						end
					end
				end
				S_WAIT_EDGE: begin
					if (rx_shift) begin
						bit_cnt <= bit_cnt + 4'd1;
						state   <= S_BIT;
					end else if (tx_shift) begin
						miso  <= tx_sr[7];
						state <= S_BIT;
					end
				end
				S_BIT: begin
					if (bit_cnt == 4'd8) begin
						rx_valid_q <= 1'b1;         // 2 cycles after 8th sample
						state      <= S_DONE;
					end else begin
						state <= S_WAIT_EDGE;
					end
				end
				S_DONE: begin
					// hold one cycle so the controller can update tx_data
					if (!rx_valid_q) begin
						bit_cnt <= 4'd0;
						first_q <= 1'b0;
						state   <= S_WAIT_EDGE;
						if (`SPI_CPHA == 1'b0) begin
							miso <= tx_data[7];
						end
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// data path
	always_ff @(posedge sys_clk) begin
		if (rx_shift) begin
			rx_sr <= {rx_sr[6:0], edges.mosi_s};                // msb first
		end
		if (tx_load) begin
			tx_sr <= `SPI_CPHA ? tx_data : {tx_data[6:0], 1'b0};  // drop bit already out
		end else if (tx_shift) begin
			tx_sr <= {tx_sr[6:0], 1'b0};
		end
	end

endmodule

`default_nettype wire

/* spi_edge_sync.sv */
//----------------------------------------------------------------------
// spi pin synchronizer
// brings cs/sclk/mosi into sys_clk and decodes frame and bit strobes
//----------------------------------------------------------------------
`include "spi_macros.svh"
`default_nettype none

module spi_edge_sync (
	input  logic                sys_clk,
	input  logic                sys_rst_n,
	input  spi_pkg::spi_pins_t  pins,
	output spi_pkg::spi_edges_t edges
);
	import spi_pkg::*;

	localparam spi_pins_t PINS_IDLE = '{cs: 1'b1, sclk: `SPI_CPOL, mosi: 1'b0};

	spi_pins_t  sync_q [`SPI_SYNC_STAGES];  // metastability chain
	spi_pins_t  cur;                        // last sync stage
	spi_pins_t  prev_q;                     // cur one cycle ago
	logic       sclk_lead;                  // sclk left idle level
	logic       sclk_trail;                 // sclk back to idle level

	assign cur        = sync_q[`SPI_SYNC_STAGES-1];
	assign sclk_lead  = (prev_q.sclk == `SPI_CPOL) && (cur.sclk != `SPI_CPOL);
	assign sclk_trail = (prev_q.sclk != `SPI_CPOL) && (cur.sclk == `SPI_CPOL);

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			for (int i = 0; i < `SPI_SYNC_STAGES; i++) begin
				sync_q[i] <= PINS_IDLE;         // look like an idle bus
			end
			prev_q <= PINS_IDLE;
		end else begin
			sync_q[0] <= pins;
			for (int i = 1; i < `SPI_SYNC_STAGES; i++) begin
				sync_q[i] <= sync_q[i-1];
			end
			prev_q <= cur;
		end
	end

	// edge register, third cycle after the pin moved
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			edges <= '0;
		end else begin
			edges.frame_start <= prev_q.cs & ~cur.cs;     // cs falling
			edges.frame_end   <= ~prev_q.cs & cur.cs;     // cs rising
			edges.sample      <= ~cur.cs & (`SPI_CPHA ? sclk_trail : sclk_lead);
			edges.shift       <= ~cur.cs & (`SPI_CPHA ? sclk_lead : sclk_trail);
			edges.mosi_s      <= cur.mosi;                // stable around sample edge
		end
	end

endmodule

`default_nettype wire

/* spi_pkg.sv */
//----------------------------------------------------------------------
// spi register slave package
// pin bundle, edge strobes, byte and register-write records, fsm enums
//----------------------------------------------------------------------
`include "spi_macros.svh"
`default_nettype none

package spi_pkg;

	typedef struct packed {
		logic cs;                           // chip select, active low
		logic sclk;                         // serial clock from master
		logic mosi;                         // master data in
	} spi_pins_t;

	typedef struct packed {
		logic frame_start;                  // cs fell
		logic frame_end;                    // cs rose
		logic sample;                       // capture mosi now
		logic shift;                        // present next miso bit
		logic mosi_s;                       // mosi, aligned with strobes
	} spi_edges_t;

	typedef struct packed {
		logic       valid;                  // one-cycle pulse
		logic       first;                  // opening byte of the frame
		logic [7:0] data;                   // received byte
	} spi_byte_t;

	typedef struct packed {
		logic                   en;         // one-cycle write pulse
		logic [`SPI_ADDR_W-1:0] addr;       // register index
		logic [7:0]             data;       // value written
	} spi_reg_wr_t;

	// byte engine
	typedef enum logic [1:0] {S_IDLE, S_WAIT_EDGE, S_BIT, S_DONE} spi_slave_state_e;

	// frame decoder
	typedef enum logic [1:0] {C_OPCODE, C_ADDR, C_DATA, C_IGNORE} spi_ctrl_state_e;

	typedef enum logic [7:0] {
		OP_WRITE = 8'h01,                   // opcode, addr, data
		OP_READ  = 8'h02                    // opcode, addr, dummy
	} spi_opcode_e;

endpackage

`default_nettype wire

/* spi_macros.svh */
//----------------------------------------------------------------------
// spi register slave macros
// spi mode, register bank size and synchronizer depth
//----------------------------------------------------------------------
`ifndef SPI_MACROS_SVH
`define SPI_MACROS_SVH

// spi mode, fixed for the whole project
`define SPI_CPOL        1'b1    // sclk idle level
`define SPI_CPHA        1'b1    // 1: sample on second edge

// register bank
`define SPI_REG_DEPTH   16      // number of registers
`define SPI_ADDR_W      4       // low address bits used

// cdc
`define SPI_SYNC_STAGES 2       // flops per input pin

`endif
